// File: logic/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

	// one command moves one byte, or places START or STOP
	typedef enum logic [2:0] {
		CMD_START_WR  = 3'd0,
		CMD_WRITE     = 3'd1,
		CMD_READ_ACK  = 3'd2,
		CMD_READ_NACK = 3'd3,
		CMD_STOP      = 3'd4
	} byte_cmd_t;

	typedef struct packed {
		byte_cmd_t  cmd;
		logic [7:0] data;
	} byte_cmd_s;

	typedef enum logic [1:0] {
		RATE_SLOWEST = 2'd0,
		RATE_SLOW    = 2'd1,
		RATE_FAST    = 2'd2,
		RATE_FASTEST = 2'd3
	} rate_t;

	// log2 of the scl half period in i_clk cycles, indexed by rate_t
	localparam logic [2:0] HALF_PERIOD_LOG [4] = '{3'd7, 3'd6, 3'd5, 3'd4};

endpackage

`default_nettype wire

// File: logic/adxl_sensor_pkg.sv
`default_nettype none

package adxl_sensor_pkg;

	// first register of each burst
	localparam logic [7:0] REG_TEMP2  = 8'h06;
	localparam logic [7:0] REG_XDATA3 = 8'h08;

	localparam int TEMP_BYTES   = 2;
	localparam int ACCEL_BYTES  = 9;
	localparam int TXN_READ_MAX = 9;

	// one register transaction, rd_count unused on writes
	typedef struct packed {
		logic       write;
		logic [7:0] reg_addr;
		logic [7:0] wdata;
		logic [3:0] rd_count;
	} txn_req_s;

	typedef enum logic [1:0] {
		POLL_TEMP  = 2'd0,
		POLL_ACCEL = 2'd1,
		POLL_ALL   = 2'd2
	} poll_mode_t;

	typedef enum logic {
		CPU_WREG = 1'b0,
		CPU_RREG = 1'b1
	} cpu_op_t;

	typedef struct packed {
		logic        [11:0] temp;
		logic signed [19:0] x;
		logic signed [19:0] y;
		logic signed [19:0] z;
	} sample_s;

endpackage

`default_nettype wire

// File: logic/i2c_bit_engine.sv
`default_nettype none

module i2c_bit_engine (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire i2c_bus_pkg::rate_t     i_rate,
	input  wire i2c_bus_pkg::byte_cmd_s i_cmd,
	input  wire                         i_cmd_valid,
	input  wire                         i_sda_in,
	input  wire                         i_scl_in,
	output logic                        o_cmd_done,
	output logic                        o_ack,
	output logic [7:0]                  o_rd_byte,
	output logic                        o_sda_low,
	output logic                        o_scl_low
);

	// every bus event lasts four quarter periods
	typedef enum logic [1:0] {
		SEG_IDLE,
		SEG_START,
		SEG_BIT,
		SEG_STOP
	} seg_t;

	seg_t                   seg;
	i2c_bus_pkg::rate_t     rate_q;
	i2c_bus_pkg::byte_cmd_t cmd_q;
	logic [1:0]             qtr;
	logic [3:0]             bit_cnt;
	logic [5:0]             div;
	logic [5:0]             div_max;
	logic [7:0]             shreg;
	logic                   samp;
	logic                   bus_free;
	logic                   stretch;
	logic                   tick;
	logic                   is_read;
	logic                   last_bit;
	logic                   bit_val;

	// quarter period is half of 2^HALF_PERIOD_LOG
	assign div_max = 6'((7'd1 << (i2c_bus_pkg::HALF_PERIOD_LOG[rate_q] - 3'd1)) - 7'd1);

	// slave may hold scl low, wait in the first high quarter
	assign stretch  = (seg != SEG_IDLE) && (qtr == 2'd2) && !i_scl_in;
	assign tick     = (seg != SEG_IDLE) && !stretch && (div == div_max);
	assign is_read  = (cmd_q == i2c_bus_pkg::CMD_READ_ACK) ||
			(cmd_q == i2c_bus_pkg::CMD_READ_NACK);
	assign last_bit = (bit_cnt == 4'd8);

	// ninth bit is the ack slot
	assign bit_val = last_bit ? (cmd_q == i2c_bus_pkg::CMD_READ_ACK) : (!is_read && !shreg[7]);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			seg        <= SEG_IDLE;
			rate_q     <= i2c_bus_pkg::RATE_SLOWEST;
			cmd_q      <= i2c_bus_pkg::CMD_STOP;
			qtr        <= 2'd0;
			bit_cnt    <= 4'd0;
			div        <= 6'd0;
			bus_free   <= 1'b1;
			o_cmd_done <= 1'b0;
			o_ack      <= 1'b0;
		end else begin
			o_cmd_done <= 1'b0;
			if (seg == SEG_IDLE) begin
				div     <= 6'd0;
				qtr     <= 2'd0;
				bit_cnt <= 4'd0;
				rate_q  <= i_rate;
				if (i_cmd_valid) begin
					cmd_q <= i_cmd.cmd;
					case (i_cmd.cmd)
						i2c_bus_pkg::CMD_START_WR: seg <= SEG_START;
						i2c_bus_pkg::CMD_STOP:     seg <= SEG_STOP;
						default:                   seg <= SEG_BIT;
					endcase
				end
			end else if (!stretch) begin
				div <= tick ? 6'd0 : div + 6'd1;
				if (tick) begin
					qtr <= qtr + 2'd1;
					if (qtr == 2'd3) begin
						case (seg)
							SEG_START: begin
								seg      <= SEG_BIT;
								bus_free <= 1'b0;
							end
							SEG_STOP: begin
								seg        <= SEG_IDLE;
								bus_free   <= 1'b1;
								o_cmd_done <= 1'b1;
							end
							default: begin
								bit_cnt <= bit_cnt + 4'd1;
								if (last_bit) begin
									seg        <= SEG_IDLE;
									o_cmd_done <= 1'b1;
									o_ack      <= !samp;
								end
							end
						endcase
					end
				end
			end
		end
	end

	// sample at mid-high, shift once scl is back low
	always_ff @(posedge i_clk) begin
		if (seg == SEG_IDLE && i_cmd_valid)
			shreg <= i_cmd.data;
		if (seg == SEG_BIT && tick && qtr == 2'd2)
			samp <= i_sda_in;
		if (seg == SEG_BIT && tick && qtr == 2'd3) begin
			if (last_bit)
				o_rd_byte <= shreg;
			else
				shreg <= {shreg[6:0], samp};
		end
	end

	// pin drive, sda only moves from the second quarter while scl is low
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_scl_low <= 1'b0;
			o_sda_low <= 1'b0;
		end else begin
			case (seg)
				SEG_START: begin
					o_scl_low <= (qtr == 2'd3);
					o_sda_low <= (qtr != 2'd0);
				end
				SEG_BIT: begin
					o_scl_low <= !qtr[1];
					if (qtr != 2'd0)
						o_sda_low <= bit_val;
				end
				SEG_STOP: begin
					o_scl_low <= !qtr[1];
					if (qtr != 2'd0)
						o_sda_low <= (qtr != 2'd3);
				end
				default: o_scl_low <= !bus_free;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/i2c_txn_ctrl.sv
`default_nettype none

module i2c_txn_ctrl #(
	parameter logic [6:0] DEV_ADDR = 7'h1D
) (
	input  wire                                          i_clk,
	input  wire                                          i_rst_n,
	input  wire                                          i_start,
	input  wire adxl_sensor_pkg::txn_req_s               i_txn,
	input  wire                                          i_cmd_done,
	input  wire                                          i_ack,
	input  wire [7:0]                                    i_rd_byte,
	output i2c_bus_pkg::byte_cmd_s                       o_cmd,
	output logic                                         o_cmd_valid,
	output logic                                         o_done,
	output logic                                         o_nack,
	output logic [adxl_sensor_pkg::TXN_READ_MAX-1:0][7:0] o_rd_bytes
);

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_ADDR_W,
		PH_REG,
		PH_WDATA,
		PH_STOP_MID,
		PH_ADDR_R,
		PH_READ,
		PH_STOP
	} phase_t;

	phase_t                    phase;
	adxl_sensor_pkg::txn_req_s txn_q;
	logic [3:0]                rd_idx;

	function automatic i2c_bus_pkg::byte_cmd_s mk_cmd(input i2c_bus_pkg::byte_cmd_t c,
			input logic [7:0] d);
		i2c_bus_pkg::byte_cmd_s bc;
		bc.cmd  = c;
		bc.data = d;
		return bc;
	endfunction

	// nack goes out on the last byte only
	function automatic i2c_bus_pkg::byte_cmd_t rd_kind(input logic [3:0] idx);
		return (idx + 4'd1 == txn_q.rd_count) ? i2c_bus_pkg::CMD_READ_NACK :
				i2c_bus_pkg::CMD_READ_ACK;
	endfunction

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase       <= PH_IDLE;
			o_cmd       <= '0;
			o_cmd_valid <= 1'b0;
			o_done      <= 1'b0;
			o_nack      <= 1'b0;
			rd_idx      <= 4'd0;
		end else begin
			o_cmd_valid <= 1'b0;
			o_done      <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (i_start) begin
						o_nack      <= 1'b0;
						o_cmd       <= mk_cmd(i2c_bus_pkg::CMD_START_WR, {DEV_ADDR, 1'b0});
						o_cmd_valid <= 1'b1;
						phase       <= PH_ADDR_W;
					end
				end
				PH_STOP: begin
					if (i_cmd_done) begin
						o_done <= 1'b1;
						phase  <= PH_IDLE;
					end
				end
				default: begin
					if (i_cmd_done) begin
						o_cmd_valid <= 1'b1;
						// any unacked address or written byte aborts
						if (phase != PH_READ && phase != PH_STOP_MID && !i_ack) begin
							o_nack <= 1'b1;
							o_cmd  <= mk_cmd(i2c_bus_pkg::CMD_STOP, 8'h00);
							phase  <= PH_STOP;
						end else begin
							case (phase)
								PH_ADDR_W: begin
									o_cmd <= mk_cmd(i2c_bus_pkg::CMD_WRITE, txn_q.reg_addr);
									phase <= PH_REG;
								end
								PH_REG: begin
									if (txn_q.write) begin
										o_cmd <= mk_cmd(i2c_bus_pkg::CMD_WRITE, txn_q.wdata);
										phase <= PH_WDATA;
									end else begin
										o_cmd <= mk_cmd(i2c_bus_pkg::CMD_STOP, 8'h00);
										phase <= PH_STOP_MID;
									end
								end
								PH_WDATA: begin
									o_cmd <= mk_cmd(i2c_bus_pkg::CMD_STOP, 8'h00);
									phase <= PH_STOP;
								end
								PH_STOP_MID: begin
									o_cmd <= mk_cmd(i2c_bus_pkg::CMD_START_WR, {DEV_ADDR, 1'b1});
									phase <= PH_ADDR_R;
								end
								PH_ADDR_R: begin
									rd_idx <= 4'd0;
									o_cmd  <= mk_cmd(rd_kind(4'd0), 8'hff);
									phase  <= PH_READ;
								end
								PH_READ: begin
									if (rd_idx + 4'd1 == txn_q.rd_count) begin
										o_cmd <= mk_cmd(i2c_bus_pkg::CMD_STOP, 8'h00);
										phase <= PH_STOP;
									end else begin
										rd_idx <= rd_idx + 4'd1;
										o_cmd  <= mk_cmd(rd_kind(rd_idx + 4'd1), 8'hff);
									end
								end
								default: phase <= PH_IDLE;
							endcase
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (phase == PH_IDLE && i_start)
			txn_q <= i_txn;
		if (phase == PH_READ && i_cmd_done)
			o_rd_bytes[rd_idx] <= i_rd_byte;
	end

endmodule

`default_nettype wire

// File: logic/i2c_bus_arbiter.sv
`default_nettype none

module i2c_bus_arbiter (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_cpu_req,
	input  wire adxl_sensor_pkg::txn_req_s i_cpu_txn,
	input  wire                            i_poll_req,
	input  wire adxl_sensor_pkg::txn_req_s i_poll_txn,
	input  wire                            i_done,
	input  wire                            i_nack,
	output logic                           o_start,
	output adxl_sensor_pkg::txn_req_s      o_txn,
	output logic                           o_cpu_done,
	output logic                           o_cpu_nack,
	output logic                           o_poll_done,
	output logic                           o_poll_nack,
	output logic                           o_busy
);

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_CPU,
		GNT_POLL
	} grant_t;

	grant_t grant;

	// completions go back to the owner only
	assign o_cpu_done  = i_done && (grant == GNT_CPU);
	assign o_cpu_nack  = i_nack && (grant == GNT_CPU);
	assign o_poll_done = i_done && (grant == GNT_POLL);
	assign o_poll_nack = i_nack && (grant == GNT_POLL);
	assign o_busy      = (grant != GNT_NONE);

	// cpu wins a tie
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			grant   <= GNT_NONE;
			o_start <= 1'b0;
		end else begin
			o_start <= 1'b0;
			if (grant == GNT_NONE) begin
				if (i_cpu_req) begin
					grant   <= GNT_CPU;
					o_start <= 1'b1;
				end else if (i_poll_req) begin
					grant   <= GNT_POLL;
					o_start <= 1'b1;
				end
			end else if (i_done) begin
				grant <= GNT_NONE;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (grant == GNT_NONE)
			o_txn <= i_cpu_req ? i_cpu_txn : i_poll_txn;
	end

endmodule

`default_nettype wire

// File: logic/cpu_reg_access.sv
`default_nettype none

module cpu_reg_access (
	input  wire                           i_clk,
	input  wire                           i_rst_n,
	input  wire                           i_cpu_req,
	input  wire adxl_sensor_pkg::cpu_op_t i_cpu_op,
	input  wire [7:0]                     i_cpu_reg,
	input  wire [7:0]                     i_cpu_wdata,
	input  wire                           i_done,
	input  wire                           i_nack,
	input  wire [7:0]                     i_rd_byte,
	output logic                          o_req,
	output adxl_sensor_pkg::txn_req_s     o_txn,
	output logic [7:0]                    o_cpu_rdata,
	output logic                          o_cpu_done
);

	// rearmed once the request level drops
	logic armed;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			armed       <= 1'b1;
			o_req       <= 1'b0;
			o_txn       <= '0;
			o_cpu_rdata <= 8'h00;
			o_cpu_done  <= 1'b0;
		end else begin
			o_cpu_done <= 1'b0;
			if (!i_cpu_req)
				armed <= 1'b1;
			if (!o_req && i_cpu_req && armed) begin
				armed          <= 1'b0;
				o_req          <= 1'b1;
				o_txn.write    <= (i_cpu_op == adxl_sensor_pkg::CPU_WREG);
				o_txn.reg_addr <= i_cpu_reg;
				o_txn.wdata    <= i_cpu_wdata;
				o_txn.rd_count <= (i_cpu_op == adxl_sensor_pkg::CPU_WREG) ? 4'd0 : 4'd1;
			end else if (o_req && i_done) begin
				o_req      <= 1'b0;
				o_cpu_done <= 1'b1;
				// a failed read leaves the last good byte
				if (!o_txn.write && !i_nack)
					o_cpu_rdata <= i_rd_byte;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/sample_poller.sv
`default_nettype none

module sample_poller (
	input  wire                                           i_clk,
	input  wire                                           i_rst_n,
	input  wire                                           i_drdy,
	input  wire adxl_sensor_pkg::poll_mode_t              i_poll_mode,
	input  wire                                           i_done,
	input  wire                                           i_nack,
	input  wire [adxl_sensor_pkg::TXN_READ_MAX-1:0][7:0]  i_rd_bytes,
	output logic                                          o_req,
	output adxl_sensor_pkg::txn_req_s                     o_txn,
	output adxl_sensor_pkg::sample_s                      o_sample,
	output logic                                          o_sample_valid
);

	typedef enum logic [1:0] {
		PS_IDLE,
		PS_TEMP,
		PS_ACCEL
	} poll_state_t;

	poll_state_t                 state;
	adxl_sensor_pkg::poll_mode_t mode_q;

	function automatic adxl_sensor_pkg::txn_req_s rd_txn(input logic [7:0] addr,
			input logic [3:0] n);
		adxl_sensor_pkg::txn_req_s t;
		t.write    = 1'b0;
		t.reg_addr = addr;
		t.wdata    = 8'h00;
		t.rd_count = n;
		return t;
	endfunction

	// high byte, middle byte, top nibble of low byte
	function automatic logic signed [19:0] axis(input logic [7:0] hi, input logic [7:0] mid,
			input logic [7:0] lo);
		return {hi, mid, lo[7:4]};
	endfunction

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state          <= PS_IDLE;
			mode_q         <= adxl_sensor_pkg::POLL_ALL;
			o_req          <= 1'b0;
			o_txn          <= '0;
			o_sample       <= '0;
			o_sample_valid <= 1'b0;
		end else begin
			o_sample_valid <= 1'b0;
			case (state)
				PS_IDLE: begin
					if (i_drdy) begin
						mode_q <= i_poll_mode;
						o_req  <= 1'b1;
						if (i_poll_mode == adxl_sensor_pkg::POLL_ACCEL) begin
							state <= PS_ACCEL;
							o_txn <= rd_txn(adxl_sensor_pkg::REG_XDATA3,
									4'(adxl_sensor_pkg::ACCEL_BYTES));
						end else begin
							state <= PS_TEMP;
							o_txn <= rd_txn(adxl_sensor_pkg::REG_TEMP2,
									4'(adxl_sensor_pkg::TEMP_BYTES));
						end
					end
				end
				PS_TEMP: begin
					if (i_done) begin
						if (i_nack) begin
							o_req <= 1'b0;
							state <= PS_IDLE;
						end else begin
							o_sample.temp <= {i_rd_bytes[0][3:0], i_rd_bytes[1]};
							// request stays up, only the transaction changes
							if (mode_q == adxl_sensor_pkg::POLL_ALL) begin
								state <= PS_ACCEL;
								o_txn <= rd_txn(adxl_sensor_pkg::REG_XDATA3,
										4'(adxl_sensor_pkg::ACCEL_BYTES));
							end else begin
								o_req          <= 1'b0;
								o_sample_valid <= 1'b1;
								state          <= PS_IDLE;
							end
						end
					end
				end
				default: begin
					if (i_done) begin
						o_req <= 1'b0;
						state <= PS_IDLE;
						if (!i_nack) begin
							o_sample.x     <= axis(i_rd_bytes[0], i_rd_bytes[1], i_rd_bytes[2]);
							o_sample.y     <= axis(i_rd_bytes[3], i_rd_bytes[4], i_rd_bytes[5]);
							o_sample.z     <= axis(i_rd_bytes[6], i_rd_bytes[7], i_rd_bytes[8]);
							o_sample_valid <= 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/adxl_i2c_top.sv
`default_nettype none

module adxl_i2c_top #(
	parameter logic [6:0] DEV_ADDR = 7'h1D
) (
	input  wire                              i_clk,
	input  wire                              i_rst_n,
	input  wire i2c_bus_pkg::rate_t          i_rate,
	input  wire                              i_cpu_req,
	input  wire adxl_sensor_pkg::cpu_op_t    i_cpu_op,
	input  wire [7:0]                        i_cpu_reg,
	input  wire [7:0]                        i_cpu_wdata,
	input  wire                              i_drdy,
	input  wire adxl_sensor_pkg::poll_mode_t i_poll_mode,
	input  wire                              i_sda_in,
	input  wire                              i_scl_in,
	output wire [7:0]                        o_cpu_rdata,
	output wire                              o_cpu_done,
	output wire adxl_sensor_pkg::sample_s    o_sample,
	output wire                              o_sample_valid,
	output wire                              o_nack,
	output wire                              o_busy,
	output wire                              o_sda_low,
	output wire                              o_scl_low
);

	logic                                          cpu_req;
	adxl_sensor_pkg::txn_req_s                     cpu_txn;
	logic                                          cpu_done;
	logic                                          cpu_nack;
	logic                                          poll_req;
	adxl_sensor_pkg::txn_req_s                     poll_txn;
	logic                                          poll_done;
	logic                                          poll_nack;
	logic                                          txn_start;
	adxl_sensor_pkg::txn_req_s                     txn;
	logic                                          txn_done;
	logic [adxl_sensor_pkg::TXN_READ_MAX-1:0][7:0] rd_bytes;
	i2c_bus_pkg::byte_cmd_s                        cmd;
	logic                                          cmd_valid;
	logic                                          cmd_done;
	logic                                          cmd_ack;
	logic [7:0]                                    cmd_rd_byte;

	cpu_reg_access u_cpu (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cpu_req   (i_cpu_req),
		.i_cpu_op    (i_cpu_op),
		.i_cpu_reg   (i_cpu_reg),
		.i_cpu_wdata (i_cpu_wdata),
		.i_done      (cpu_done),
		.i_nack      (cpu_nack),
		.i_rd_byte   (rd_bytes[0]),
		.o_req       (cpu_req),
		.o_txn       (cpu_txn),
		.o_cpu_rdata (o_cpu_rdata),
		.o_cpu_done  (o_cpu_done)
	);

	sample_poller u_poller (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_drdy         (i_drdy),
		.i_poll_mode    (i_poll_mode),
		.i_done         (poll_done),
		.i_nack         (poll_nack),
		.i_rd_bytes     (rd_bytes),
		.o_req          (poll_req),
		.o_txn          (poll_txn),
		.o_sample       (o_sample),
		.o_sample_valid (o_sample_valid)
	);

	i2c_bus_arbiter u_arb (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cpu_req   (cpu_req),
		.i_cpu_txn   (cpu_txn),
		.i_poll_req  (poll_req),
		.i_poll_txn  (poll_txn),
		.i_done      (txn_done),
		.i_nack      (o_nack),
		.o_start     (txn_start),
		.o_txn       (txn),
		.o_cpu_done  (cpu_done),
		.o_cpu_nack  (cpu_nack),
		.o_poll_done (poll_done),
		.o_poll_nack (poll_nack),
		.o_busy      (o_busy)
	);

	i2c_txn_ctrl #(
		.DEV_ADDR (DEV_ADDR)
	) u_txn (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (txn_start),
		.i_txn       (txn),
		.i_cmd_done  (cmd_done),
		.i_ack       (cmd_ack),
		.i_rd_byte   (cmd_rd_byte),
		.o_cmd       (cmd),
		.o_cmd_valid (cmd_valid),
		.o_done      (txn_done),
		.o_nack      (o_nack),
		.o_rd_bytes  (rd_bytes)
	);

	i2c_bit_engine u_bit (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rate      (i_rate),
		.i_cmd       (cmd),
		.i_cmd_valid (cmd_valid),
		.i_sda_in    (i_sda_in),
		.i_scl_in    (i_scl_in),
		.o_cmd_done  (cmd_done),
		.o_ack       (cmd_ack),
		.o_rd_byte   (cmd_rd_byte),
		.o_sda_low   (o_sda_low),
		.o_scl_low   (o_scl_low)
	);

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// reset held for 8 rising edges
	initial begin
		o_rst_n = 1'b0;
		repeat (8) @(posedge o_clk);
		#1 o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/adxl_slave_model.sv
`default_nettype none

module adxl_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h1D
) (
	input  wire i_sda_low,
	input  wire i_scl_low,
	input  wire i_respond,
	output wire o_sda,
	output wire o_scl
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] regs [256];
	logic [7:0] ptr;
	logic [7:0] shreg;
	logic [7:0] tx;
	logic [3:0] bit_cnt;
	logic       active;
	logic       rd_mode;
	logic       addr_byte;
	logic       got_reg;
	logic       clocked;
	logic       mstr_nack;
	logic       drive_low;
	integer     seed;
	integer     i;

	// wired-AND of both open-drain drivers
	assign o_sda = !(i_sda_low || drive_low);
	assign o_scl = !i_scl_low;

	initial begin
		seed = 38094;
		for (i = 0; i < 256; i++)
			regs[i] = 8'($random(seed));
		active    = 1'b0;
		rd_mode   = 1'b0;
		addr_byte = 1'b0;
		got_reg   = 1'b0;
		clocked   = 1'b0;
		mstr_nack = 1'b0;
		drive_low = 1'b0;
		bit_cnt   = 4'd0;
		ptr       = 8'h00;
	end

	// start or repeated start
	always @(negedge o_sda) begin
		if (o_scl) begin
			active    = 1'b1;
			addr_byte = 1'b1;
			got_reg   = 1'b0;
			rd_mode   = 1'b0;
			clocked   = 1'b0;
			bit_cnt   = 4'd0;
			drive_low = 1'b0;
		end
	end

	// stop
	always @(posedge o_sda) begin
		if (o_scl) begin
			active    = 1'b0;
			drive_low = 1'b0;
		end
	end

	always @(posedge o_scl) begin
		if (active) begin
			clocked = 1'b1;
			if (bit_cnt < 4'd8) begin
				if (!rd_mode)
					shreg = {shreg[6:0], o_sda};
				bit_cnt = bit_cnt + 4'd1;
			end else begin
				if (rd_mode)
					mstr_nack = o_sda;
				bit_cnt = 4'd9;
			end
		end
	end

	// sda only moves while scl is low
	always @(negedge o_scl) begin
		if (active && clocked) begin
			clocked = 1'b0;
			if (bit_cnt == 4'd8) begin
				if (rd_mode) begin
					drive_low = 1'b0;
				end else if (addr_byte) begin
					addr_byte = 1'b0;
					if (shreg[7:1] == DEV_ADDR && i_respond) begin
						drive_low = 1'b1;
						rd_mode   = shreg[0];
					end else begin
						active = 1'b0;
					end
				end else if (!got_reg) begin
					ptr       = shreg;
					got_reg   = 1'b1;
					drive_low = 1'b1;
				end else begin
					regs[ptr] = shreg;
					ptr       = ptr + 8'd1;
					drive_low = 1'b1;
				end
			end else if (bit_cnt == 4'd9) begin
				bit_cnt   = 4'd0;
				drive_low = 1'b0;
				if (rd_mode) begin
					if (mstr_nack) begin
						active = 1'b0;
					end else begin
						tx        = regs[ptr];
						ptr       = ptr + 8'd1;
						drive_low = !tx[7];
					end
				end
			end else if (rd_mode) begin
				drive_low = !tx[3'd7 - bit_cnt[2:0]];
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/adxl_i2c_tb.sv
`default_nettype none

module adxl_i2c_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [6:0] DEV_ADDR = 7'h1D;
	// byte commands over all tests, bounded at the slowest rate
	localparam longint TOTAL_CMDS  = 122;
	localparam longint WATCHDOG_NS = TOTAL_CMDS * 9 * 2 * 128 * 4 * 4;

	logic                        clk;
	logic                        rst_n;
	i2c_bus_pkg::rate_t          rate;
	logic                        cpu_req;
	adxl_sensor_pkg::cpu_op_t    cpu_op;
	logic [7:0]                  cpu_reg;
	logic [7:0]                  cpu_wdata;
	logic                        drdy;
	adxl_sensor_pkg::poll_mode_t poll_mode;
	logic                        respond;
	wire                         sda;
	wire                         scl;
	wire  [7:0]                  o_cpu_rdata;
	wire                         o_cpu_done;
	adxl_sensor_pkg::sample_s    o_sample;
	wire                         o_sample_valid;
	wire                         o_nack;
	wire                         o_busy;
	wire                         sda_low;
	wire                         scl_low;

	logic [7:0]                  shadow [256];
	logic [7:0]                  exp_rdata;
	logic                        chk_rdata;
	logic                        exp_nack;
	adxl_sensor_pkg::sample_s    exp_sample;
	int                          errors;
	int                          passes;
	int                          fails;
	int                          cpu_done_cnt;
	int                          sample_cnt;
	time                         cpu_done_time;
	time                         sample_time;
	int                          err_mark;

	tb_clk_gen u_clk (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	adxl_i2c_top #(
		.DEV_ADDR (DEV_ADDR)
	) i_dut (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_rate         (rate),
		.i_cpu_req      (cpu_req),
		.i_cpu_op       (cpu_op),
		.i_cpu_reg      (cpu_reg),
		.i_cpu_wdata    (cpu_wdata),
		.i_drdy         (drdy),
		.i_poll_mode    (poll_mode),
		.i_sda_in       (sda),
		.i_scl_in       (scl),
		.o_cpu_rdata    (o_cpu_rdata),
		.o_cpu_done     (o_cpu_done),
		.o_sample       (o_sample),
		.o_sample_valid (o_sample_valid),
		.o_nack         (o_nack),
		.o_busy         (o_busy),
		.o_sda_low      (sda_low),
		.o_scl_low      (scl_low)
	);

	adxl_slave_model #(
		.DEV_ADDR (DEV_ADDR)
	) u_slave (
		.i_sda_low (sda_low),
		.i_scl_low (scl_low),
		.i_respond (respond),
		.o_sda     (sda),
		.o_scl     (scl)
	);

	// decode of the sensor registers 0x06 to 0x10
	function automatic adxl_sensor_pkg::sample_s ref_sample(
			input adxl_sensor_pkg::sample_s prev, input adxl_sensor_pkg::poll_mode_t mode);
		adxl_sensor_pkg::sample_s s;
		s = prev;
		if (mode != adxl_sensor_pkg::POLL_ACCEL)
			s.temp = {shadow[8'h06][3:0], shadow[8'h07]};
		if (mode != adxl_sensor_pkg::POLL_TEMP) begin
			s.x = {shadow[8'h08], shadow[8'h09], shadow[8'h0a][7:4]};
			s.y = {shadow[8'h0b], shadow[8'h0c], shadow[8'h0d][7:4]};
			s.z = {shadow[8'h0e], shadow[8'h0f], shadow[8'h10][7:4]};
		end
		return s;
	endfunction

	function automatic logic [7:0] ref_reg(input logic [7:0] addr);
		return shadow[addr];
	endfunction

	task automatic check_val(input string name, input logic [71:0] got,
			input logic [71:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// outputs are read half a cycle after they change
	always @(negedge clk) begin
		if (o_cpu_done) begin
			cpu_done_cnt++;
			cpu_done_time = $time;
			check_val("o_nack", 72'(o_nack), 72'(exp_nack));
			if (chk_rdata)
				check_val("o_cpu_rdata", 72'(o_cpu_rdata), 72'(exp_rdata));
		end
		if (o_sample_valid) begin
			sample_cnt++;
			sample_time = $time;
			check_val("o_sample", 72'(o_sample), 72'(exp_sample));
		end
	end

	task automatic run_cpu(input adxl_sensor_pkg::cpu_op_t op, input logic [7:0] addr,
			input logic [7:0] data, input logic expect_nack);
		int n;
		n         = cpu_done_cnt;
		exp_nack  = expect_nack;
		chk_rdata = (op == adxl_sensor_pkg::CPU_RREG) && !expect_nack;
		exp_rdata = ref_reg(addr);
		@(posedge clk);
		#1;
		cpu_op    = op;
		cpu_reg   = addr;
		cpu_wdata = data;
		cpu_req   = 1'b1;
		wait (cpu_done_cnt == n + 1);
		@(posedge clk);
		#1 cpu_req = 1'b0;
		if (op == adxl_sensor_pkg::CPU_WREG && !expect_nack)
			shadow[addr] = data;
	endtask

	task automatic run_poll(input adxl_sensor_pkg::poll_mode_t mode);
		int n;
		n          = sample_cnt;
		exp_nack   = 1'b0;
		exp_sample = ref_sample(exp_sample, mode);
		@(posedge clk);
		#1;
		poll_mode = mode;
		drdy      = 1'b1;
		@(posedge clk);
		#1 drdy = 1'b0;
		wait (sample_cnt == n + 1);
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			$display("test %s: ok", name);
			passes++;
		end else begin
			$display("test %s: failed", name);
			fails++;
		end
		err_mark = errors;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int c;
		int s;
		rate         = i2c_bus_pkg::RATE_FASTEST;
		cpu_req      = 1'b0;
		cpu_op       = adxl_sensor_pkg::CPU_RREG;
		cpu_reg      = 8'h00;
		cpu_wdata    = 8'h00;
		drdy         = 1'b0;
		poll_mode    = adxl_sensor_pkg::POLL_ALL;
		respond      = 1'b1;
		exp_rdata    = 8'h00;
		chk_rdata    = 1'b0;
		exp_nack     = 1'b0;
		exp_sample   = '0;
		errors       = 0;
		passes       = 0;
		fails        = 0;
		err_mark     = 0;
		cpu_done_cnt = 0;
		sample_cnt   = 0;
		wait (rst_n);
		@(negedge clk);
		for (int i = 0; i < 256; i++)
			shadow[i] = u_slave.regs[i];

		// bus released and engine idle out of reset
		check_val("o_sda_low", 72'(sda_low), 72'(0));
		check_val("o_scl_low", 72'(scl_low), 72'(0));
		check_val("o_busy", 72'(o_busy), 72'(0));
		check_val("o_nack", 72'(o_nack), 72'(0));
		end_test("idle after reset");

		// sign bit set in the x high byte
		run_cpu(adxl_sensor_pkg::CPU_WREG, 8'h08, 8'h9a, 1'b0);
		run_cpu(adxl_sensor_pkg::CPU_RREG, 8'h08, 8'h00, 1'b0);
		end_test("write then read back");

		for (int r = 0; r < 4; r++) begin
			rate = i2c_bus_pkg::rate_t'(r);
			run_cpu(adxl_sensor_pkg::CPU_RREG, 8'h20 + 8'(r), 8'h00, 1'b0);
		end
		rate = i2c_bus_pkg::RATE_FASTEST;
		end_test("read at each rate");

		run_poll(adxl_sensor_pkg::POLL_ALL);
		end_test("poll all");

		run_cpu(adxl_sensor_pkg::CPU_WREG, 8'h07, 8'h5c, 1'b0);
		run_cpu(adxl_sensor_pkg::CPU_WREG, 8'h09, 8'h11, 1'b0);
		run_poll(adxl_sensor_pkg::POLL_TEMP);
		// temperature register moves, accel poll must not pick it up
		run_cpu(adxl_sensor_pkg::CPU_WREG, 8'h07, 8'ha3, 1'b0);
		run_poll(adxl_sensor_pkg::POLL_ACCEL);
		end_test("poll temp and accel modes");

		respond = 1'b0;
		run_cpu(adxl_sensor_pkg::CPU_RREG, 8'h06, 8'h00, 1'b1);
		@(negedge clk);
		check_val("o_busy", 72'(o_busy), 72'(0));
		s = sample_cnt;
		@(posedge clk);
		#1 drdy = 1'b1;
		@(posedge clk);
		#1 drdy = 1'b0;
		wait (o_busy);
		wait (!o_busy);
		repeat (2) @(negedge clk);
		check_val("o_nack", 72'(o_nack), 72'(1));
		if (sample_cnt != s) begin
			$display("poll without a slave response still gave a valid sample");
			errors++;
		end
		respond = 1'b1;
		end_test("no slave response");

		c          = cpu_done_cnt;
		s          = sample_cnt;
		exp_nack   = 1'b0;
		chk_rdata  = 1'b1;
		exp_rdata  = ref_reg(8'h30);
		exp_sample = ref_sample(exp_sample, adxl_sensor_pkg::POLL_ALL);
		@(posedge clk);
		#1;
		cpu_op    = adxl_sensor_pkg::CPU_RREG;
		cpu_reg   = 8'h30;
		cpu_req   = 1'b1;
		poll_mode = adxl_sensor_pkg::POLL_ALL;
		drdy      = 1'b1;
		@(posedge clk);
		#1 drdy = 1'b0;
		wait (cpu_done_cnt == c + 1);
		@(posedge clk);
		#1 cpu_req = 1'b0;
		wait (sample_cnt == s + 1);
		if (!(cpu_done_time < sample_time)) begin
			$display("CPU result did not arrive before the sample");
			errors++;
		end
		end_test("simultaneous CPU and poll");

		$display("tests passed %0d, failed %0d", passes, fails);
		if (fails == 0 && errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: adxl_i2c_top.f
logic/i2c_bus_pkg.sv
logic/adxl_sensor_pkg.sv
logic/i2c_bit_engine.sv
logic/i2c_txn_ctrl.sv
logic/i2c_bus_arbiter.sv
logic/cpu_reg_access.sv
logic/sample_poller.sv
logic/adxl_i2c_top.sv
verif/tb_clk_gen.sv
verif/adxl_slave_model.sv
verif/adxl_i2c_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = adxl_i2c_tb
FILELIST  = adxl_i2c_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
